// File: robocup_pkg.sv
`default_nettype none

package robocup_pkg;

	// Sent as byte 0 of every transfer
	localparam logic [7:0] LOGIC_VERSION = 8'h03;

	// Command codes in byte 0 from the MCU
	localparam logic [7:0] CMD_READ_STATUS = 8'h00;
	localparam logic [7:0] CMD_WRITE_MOTORS = 8'h01;

	// Returned for any command we don't know
	localparam logic [7:0] INVALID_FILL = 8'hEE;

	localparam int NUM_MOTORS = 5;
	localparam int NUM_ENCODERS = 4;
	localparam int SPEED_BITS = 9;
	localparam int ENC_BITS = 16;

	// Byte numbering within one transfer
	localparam int BYTE_IDX_BITS = 4;
	localparam logic [BYTE_IDX_BITS-1:0] MAX_RX_BYTES = 4'd15;
	localparam logic [BYTE_IDX_BITS-1:0] WRITE_LEN = 4'd12;

	// Triangle turns around here, so the phase peaks at 0x1FE
	localparam logic [SPEED_BITS-1:0] PWM_TOP = 9'h1FD;

	localparam int WATCHDOG_BITS = 16;

	// Kick pulse is strength * KICK_SCALE cycles, 255 * 16 fits in 12 bits
	localparam int PULSE_BITS = 12;
	localparam logic [PULSE_BITS-1:0] KICK_SCALE = 12'd16;

	// Dead time after a pulse before another kick is taken
	localparam int LOCKOUT_BITS = 11;
	localparam logic [LOCKOUT_BITS-1:0] KICK_LOCKOUT = 11'd1024;

endpackage

`default_nettype wire

// File: spi_link_if.sv
`timescale 1ns/1ps
`default_nettype none

interface spi_link_if;

	// Strobes and data from the SPI engine
	logic start;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic [robocup_pkg::BYTE_IDX_BITS-1:0] rx_index;
	logic tx_load;
	logic [robocup_pkg::BYTE_IDX_BITS-1:0] tx_index;
	logic done;
	logic [robocup_pkg::BYTE_IDX_BITS-1:0] count;

	// Next byte to shift out, valid while tx_load is high
	logic [7:0] tx_byte;

	modport link_slave (
		output start, rx_valid, rx_byte, rx_index, tx_load, tx_index, done, count,
		input tx_byte
	);

	modport link_regs (
		input start, rx_valid, rx_byte, rx_index, tx_load, tx_index, done, count,
		output tx_byte
	);

endinterface

`default_nettype wire

// File: spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

// SPI mode 0 slave, SCK no faster than sysclk/8
module spi_slave (
	input logic sysclk,
	input logic reset,
	input logic sck,
	input logic mosi,
	input logic ncs,
	output logic miso,
	output logic miso_oe,
	spi_link_if.link_slave link
);

	// Two-flop synchronizers, plus one delayed copy for edge detect
	logic sck_meta, sck_s, sck_d;
	logic mosi_meta, mosi_s;
	logic ncs_meta, ncs_s, ncs_d;

	logic sck_rise;
	logic sck_fall;

	// MOSI as seen at the last SCK rise
	logic mosi_sampled;

	logic [2:0] bit_count;
	logic [robocup_pkg::BYTE_IDX_BITS-1:0] byte_count;

	// Shared shift register, MSB goes out first
	logic [7:0] shift;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			sck_meta <= 1'b0;
			sck_s <= 1'b0;
			sck_d <= 1'b0;
			// Deselected at reset so no false start strobe
			ncs_meta <= 1'b1;
			ncs_s <= 1'b1;
			ncs_d <= 1'b1;
		end else begin
			sck_meta <= sck;
			sck_s <= sck_meta;
			sck_d <= sck_s;
			ncs_meta <= ncs;
			ncs_s <= ncs_meta;
			ncs_d <= ncs_s;
		end
	end

	always_ff @(posedge sysclk) begin
		mosi_meta <= mosi;
		mosi_s <= mosi_meta;
	end

	assign sck_rise = sck_s & ~sck_d;
	assign sck_fall = ~sck_s & sck_d;

	// Bit and byte counters
	always_ff @(posedge sysclk) begin
		if (reset) begin
			bit_count <= 3'd0;
			byte_count <= '0;
			link.rx_valid <= 1'b0;
			miso_oe <= 1'b0;
		end else begin
			miso_oe <= ~ncs_s;
			link.rx_valid <= 1'b0;
			if (ncs_s) begin
				bit_count <= 3'd0;
				byte_count <= '0;
			end else if (sck_rise) begin
				bit_count <= bit_count + 3'd1;
				// Last bit of a byte, stop counting once storage is full
				if (bit_count == 3'd7 && byte_count < robocup_pkg::MAX_RX_BYTES) begin
					link.rx_valid <= 1'b1;
					byte_count <= byte_count + 1'b1;
				end
			end
		end
	end

	// Data path
	always_ff @(posedge sysclk) begin
		if (sck_rise) begin
			mosi_sampled <= mosi_s;
		end
		if (sck_rise && bit_count == 3'd7) begin
			link.rx_byte <= {shift[6:0], mosi_s};
			link.rx_index <= byte_count;
		end
		if (ncs_s) begin
			// Byte 0 waits here while deselected
			shift <= robocup_pkg::LOGIC_VERSION;
		end else if (link.tx_load) begin
			shift <= link.tx_byte;
		end else if (sck_fall && bit_count != 3'd0) begin
			shift <= {shift[6:0], mosi_sampled};
		end
	end

	assign miso = shift[7];

	// Fall with bit_count wrapped to 0 begins the next byte
	assign link.tx_load = ~ncs_s & sck_fall & (bit_count == 3'd0);
	assign link.tx_index = byte_count;

	assign link.start = ncs_d & ~ncs_s;
	assign link.done = ~ncs_d & ncs_s;
	assign link.count = byte_count;

endmodule

`default_nettype wire

// File: robot_regs.sv
`timescale 1ns/1ps
`default_nettype none

module robot_regs (
	input logic sysclk,
	input logic reset,
	spi_link_if.link_regs link,
	input logic [robocup_pkg::NUM_MOTORS-1:0] fault,
	input logic [robocup_pkg::ENC_BITS-1:0] enc_count_1,
	input logic [robocup_pkg::ENC_BITS-1:0] enc_count_2,
	input logic [robocup_pkg::ENC_BITS-1:0] enc_count_3,
	input logic [robocup_pkg::ENC_BITS-1:0] enc_count_4,
	input logic [7:0] kick_status,
	output logic [robocup_pkg::SPEED_BITS-1:0] speed_1,
	output logic [robocup_pkg::SPEED_BITS-1:0] speed_2,
	output logic [robocup_pkg::SPEED_BITS-1:0] speed_3,
	output logic [robocup_pkg::SPEED_BITS-1:0] speed_4,
	output logic [robocup_pkg::SPEED_BITS-1:0] speed_5,
	output logic [robocup_pkg::NUM_MOTORS-1:0] dir,
	output logic charge_enable,
	output logic kick_request,
	output logic kick_select,
	output logic [7:0] kick_strength
);

	// Bytes of the current transfer, byte 0 is the command
	logic [7:0] rx_mem [robocup_pkg::MAX_RX_BYTES];
	logic [7:0] command;

	// Counts frozen at the start of a transfer
	logic [robocup_pkg::ENC_BITS-1:0] enc_cap [robocup_pkg::NUM_ENCODERS];

	logic [robocup_pkg::SPEED_BITS-1:0] speed_q [robocup_pkg::NUM_MOTORS];
	logic [robocup_pkg::WATCHDOG_BITS-1:0] watchdog;
	logic write_accept;

	always_ff @(posedge sysclk) begin
		if (link.rx_valid) begin
			rx_mem[link.rx_index] <= link.rx_byte;
		end
		if (link.start) begin
			enc_cap[0] <= enc_count_1;
			enc_cap[1] <= enc_count_2;
			enc_cap[2] <= enc_count_3;
			enc_cap[3] <= enc_count_4;
		end
	end

	assign command = rx_mem[0];

	// Only a motor write of exactly the right length counts
	assign write_accept = link.done && command == robocup_pkg::CMD_WRITE_MOTORS &&
		link.count == robocup_pkg::WRITE_LEN;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
				speed_q[m] <= '0;
			end
			dir <= '0;
			charge_enable <= 1'b0;
			kick_select <= 1'b0;
			kick_strength <= 8'h00;
			kick_request <= 1'b0;
			watchdog <= '0;
		end else begin
			kick_request <= 1'b0;
			if (write_accept) begin
				watchdog <= '0;
				// 16-bit little-endian field per motor: speed 8:0, dir 9
				for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
					speed_q[m] <= {rx_mem[2 * m + 2][0], rx_mem[2 * m + 1]};
					dir[m] <= rx_mem[2 * m + 2][1];
				end
				charge_enable <= rx_mem[10][7];
				kick_select <= rx_mem[10][6];
				kick_strength <= rx_mem[11];
				kick_request <= (rx_mem[11] != 8'h00);
			end else if (watchdog == '1) begin
				// Timed out, stop motors and charging
				for (int m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin
					speed_q[m] <= '0;
				end
				dir <= '0;
				charge_enable <= 1'b0;
			end else begin
				watchdog <= watchdog + 1'b1;
			end
		end
	end

	assign speed_1 = speed_q[0];
	assign speed_2 = speed_q[1];
	assign speed_3 = speed_q[2];
	assign speed_4 = speed_q[3];
	assign speed_5 = speed_q[4];

	// Transmit byte, consumed by the SPI engine in the tx_load cycle
	always_comb begin
		case (command)
			robocup_pkg::CMD_READ_STATUS: begin
				case (link.tx_index)
					// Counts go out low byte first
					4'd1: link.tx_byte = enc_cap[0][7:0];
					4'd2: link.tx_byte = enc_cap[0][15:8];
					4'd3: link.tx_byte = enc_cap[1][7:0];
					4'd4: link.tx_byte = enc_cap[1][15:8];
					4'd5: link.tx_byte = enc_cap[2][7:0];
					4'd6: link.tx_byte = enc_cap[2][15:8];
					4'd7: link.tx_byte = enc_cap[3][7:0];
					4'd8: link.tx_byte = enc_cap[3][15:8];
					4'd9: link.tx_byte = {{(8 - robocup_pkg::NUM_MOTORS){1'b0}}, fault};
					4'd10: link.tx_byte = kick_status;
					default: link.tx_byte = 8'h00;
				endcase
			end
			// Nothing useful to return during a write
			robocup_pkg::CMD_WRITE_MOTORS: link.tx_byte = 8'h00;
			default: link.tx_byte = robocup_pkg::INVALID_FILL;
		endcase
	end

endmodule

`default_nettype wire

// File: motor_driver.sv
`timescale 1ns/1ps
`default_nettype none

module motor_driver (
	input logic sysclk,
	input logic reset,
	input logic [robocup_pkg::SPEED_BITS-1:0] pwm_phase,
	input logic dir,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed,
	input logic [2:0] hall,
	output logic [5:0] drive,
	output logic fault
);

	logic [2:0] hall_meta, hall_s;

	// One-hot phase selects, bit 2 is phase a
	logic [2:0] high_sel, low_sel;
	logic [2:0] high_on, low_on;
	logic hall_bad;
	logic pwm_on;

	always_ff @(posedge sysclk) begin
		hall_meta <= hall;
		hall_s <= hall_meta;
	end

	// Six-step table for the forward direction
	always_comb begin
		case (hall_s)
			3'b100: begin high_sel = 3'b100; low_sel = 3'b010; end
			3'b110: begin high_sel = 3'b100; low_sel = 3'b001; end
			3'b010: begin high_sel = 3'b010; low_sel = 3'b001; end
			3'b011: begin high_sel = 3'b010; low_sel = 3'b100; end
			3'b001: begin high_sel = 3'b001; low_sel = 3'b100; end
			3'b101: begin high_sel = 3'b001; low_sel = 3'b010; end
			// 000 and 111 are sensor faults, everything off
			default: begin high_sel = 3'b000; low_sel = 3'b000; end
		endcase
	end

	assign hall_bad = (hall_s == 3'b000) || (hall_s == 3'b111);

	// Reverse swaps which side drives
	assign high_on = dir ? low_sel : high_sel;
	assign low_on = dir ? high_sel : low_sel;

	assign pwm_on = pwm_phase < speed;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			drive <= 6'b000000;
			fault <= 1'b0;
		end else begin
			fault <= hall_bad;
			// Only the high side is chopped
			drive <= {high_on[2] & pwm_on, low_on[2],
				high_on[1] & pwm_on, low_on[1],
				high_on[0] & pwm_on, low_on[0]};
		end
	end

endmodule

`default_nettype wire

// File: motor_array.sv
`timescale 1ns/1ps
`default_nettype none

module motor_array (
	input logic sysclk,
	input logic reset,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed_1,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed_2,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed_3,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed_4,
	input logic [robocup_pkg::SPEED_BITS-1:0] speed_5,
	input logic [robocup_pkg::NUM_MOTORS-1:0] dir,
	input logic [3 * robocup_pkg::NUM_MOTORS-1:0] hall,
	output logic [6 * robocup_pkg::NUM_MOTORS-1:0] bridge,
	output logic [robocup_pkg::NUM_MOTORS-1:0] fault
);

	// Shared triangle phase, 0 up to 0x1FE and back
	logic [robocup_pkg::SPEED_BITS-1:0] pwm_phase;
	logic pwm_down;

	logic [robocup_pkg::SPEED_BITS-1:0] speed [robocup_pkg::NUM_MOTORS];

	assign speed[0] = speed_1;
	assign speed[1] = speed_2;
	assign speed[2] = speed_3;
	assign speed[3] = speed_4;
	assign speed[4] = speed_5;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			pwm_phase <= '0;
			pwm_down <= 1'b0;
		end else if (!pwm_down) begin
			if (pwm_phase == robocup_pkg::PWM_TOP) begin
				pwm_down <= 1'b1;
			end
			pwm_phase <= pwm_phase + 1'b1;
		end else begin
			// Turn around when stepping back to 0
			if (pwm_phase == 9'd1) begin
				pwm_down <= 1'b0;
			end
			pwm_phase <= pwm_phase - 1'b1;
		end
	end

	// Motor m uses hall[3m+2:3m] = {a,b,c} and bridge[6m+5:6m]
	for (genvar m = 0; m < robocup_pkg::NUM_MOTORS; m++) begin : g_motor
		motor_driver i_motor_driver (
			.sysclk(sysclk),
			.reset(reset),
			.pwm_phase(pwm_phase),
			.dir(dir[m]),
			.speed(speed[m]),
			.hall(hall[3 * m +: 3]),
			.drive(bridge[6 * m +: 6]),
			.fault(fault[m])
		);
	end

endmodule

`default_nettype wire

// File: quad_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module quad_encoder (
	input logic sysclk,
	input logic reset,
	input logic enc_a,
	input logic enc_b,
	output logic [robocup_pkg::ENC_BITS-1:0] count
);

	logic a_meta, a_s;
	logic b_meta, b_s;
	logic [1:0] prev;

	always_ff @(posedge sysclk) begin
		a_meta <= enc_a;
		a_s <= a_meta;
		b_meta <= enc_b;
		b_s <= b_meta;
		prev <= {a_s, b_s};
	end

	always_ff @(posedge sysclk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({prev, a_s, b_s})
				// A leads B
				4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: count <= count + 1'b1;
				// B leads A
				4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: count <= count - 1'b1;
				// No change, or a double step we can't resolve
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: kicker.sv
`timescale 1ns/1ps
`default_nettype none

module kicker (
	input logic sysclk,
	input logic reset,
	input logic kick_request,
	input logic kick_select,
	input logic [7:0] kick_strength,
	input logic charge_enable,
	input logic discharge_n,
	input logic kdone,
	output logic kcharge,
	output logic kkick,
	output logic kchip,
	output logic [7:0] status
);

	logic dis_meta, dis_s;
	logic done_meta, done_s;

	// Set by the discharge button, cleared only by reset
	logic override;

	logic [robocup_pkg::PULSE_BITS-1:0] pulse_len;
	logic [robocup_pkg::PULSE_BITS-1:0] pulse_cnt;
	logic [robocup_pkg::LOCKOUT_BITS-1:0] lockout_cnt;
	logic idle;
	logic lockout;

	always_ff @(posedge sysclk) begin
		dis_meta <= discharge_n;
		dis_s <= dis_meta;
		done_meta <= kdone;
		done_s <= done_meta;
	end

	assign pulse_len = {{(robocup_pkg::PULSE_BITS - 8){1'b0}}, kick_strength} *
		robocup_pkg::KICK_SCALE;

	assign idle = (pulse_cnt == '0) && (lockout_cnt == '0);
	assign lockout = lockout_cnt != '0;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			override <= 1'b0;
			kcharge <= 1'b0;
			kkick <= 1'b0;
			kchip <= 1'b0;
			pulse_cnt <= '0;
			lockout_cnt <= '0;
		end else begin
			if (!dis_s) begin
				override <= 1'b1;
			end
			kcharge <= charge_enable & ~override;

			if (kick_request && idle) begin
				// Fire now, routed by select
				pulse_cnt <= pulse_len;
				kkick <= ~kick_select;
				kchip <= kick_select;
			end else if (pulse_cnt != '0) begin
				pulse_cnt <= pulse_cnt - 1'b1;
				// Last pulse cycle, start the lockout
				if (pulse_cnt == 1) begin
					kkick <= 1'b0;
					kchip <= 1'b0;
					lockout_cnt <= robocup_pkg::KICK_LOCKOUT;
				end
			end else if (lockout) begin
				lockout_cnt <= lockout_cnt - 1'b1;
			end
		end
	end

	assign status = {2'b00, kick_select, override, charge_enable, kcharge, lockout, done_s};

endmodule

`default_nettype wire

// File: robot_fpga.sv
`timescale 1ns/1ps
`default_nettype none

module robot_fpga (
	input logic sysclk,
	input logic reset,
	// MCU link
	input logic sck, mosi, fpga_ncs,
	output logic miso, miso_oe,
	// Hall sensors
	input logic m1hall_a, m1hall_b, m1hall_c,
	input logic m2hall_a, m2hall_b, m2hall_c,
	input logic m3hall_a, m3hall_b, m3hall_c,
	input logic m4hall_a, m4hall_b, m4hall_c,
	input logic m5hall_a, m5hall_b, m5hall_c,
	// Half bridges
	output logic m1a_h, m1a_l, m1b_h, m1b_l, m1c_h, m1c_l,
	output logic m2a_h, m2a_l, m2b_h, m2b_l, m2c_h, m2c_l,
	output logic m3a_h, m3a_l, m3b_h, m3b_l, m3c_h, m3c_l,
	output logic m4a_h, m4a_l, m4b_h, m4b_l, m4c_h, m4c_l,
	output logic m5a_h, m5a_l, m5b_h, m5b_l, m5c_h, m5c_l,
	// Encoders
	input logic m1enc_a, m1enc_b,
	input logic m2enc_a, m2enc_b,
	input logic m3enc_a, m3enc_b,
	input logic m4enc_a, m4enc_b,
	// Kicker board
	input logic discharge, kdone,
	output logic kcharge, kkick, kchip
);

	logic [robocup_pkg::SPEED_BITS-1:0] speed_1, speed_2, speed_3, speed_4, speed_5;
	logic [robocup_pkg::NUM_MOTORS-1:0] dir;
	logic [robocup_pkg::NUM_MOTORS-1:0] fault;
	logic [3 * robocup_pkg::NUM_MOTORS-1:0] hall;
	logic [6 * robocup_pkg::NUM_MOTORS-1:0] bridge;
	logic [robocup_pkg::ENC_BITS-1:0] enc_1, enc_2, enc_3, enc_4;
	logic charge_enable, kick_request, kick_select;
	logic [7:0] kick_strength;
	logic [7:0] kick_status;

	spi_link_if link ();

	// Motor 1 in the low bits
	assign hall = {m5hall_a, m5hall_b, m5hall_c, m4hall_a, m4hall_b, m4hall_c,
		m3hall_a, m3hall_b, m3hall_c, m2hall_a, m2hall_b, m2hall_c,
		m1hall_a, m1hall_b, m1hall_c};
	assign {m5a_h, m5a_l, m5b_h, m5b_l, m5c_h, m5c_l,
		m4a_h, m4a_l, m4b_h, m4b_l, m4c_h, m4c_l,
		m3a_h, m3a_l, m3b_h, m3b_l, m3c_h, m3c_l,
		m2a_h, m2a_l, m2b_h, m2b_l, m2c_h, m2c_l,
		m1a_h, m1a_l, m1b_h, m1b_l, m1c_h, m1c_l} = bridge;

	spi_slave i_spi_slave (.sysclk(sysclk), .reset(reset), .sck(sck), .mosi(mosi),
		.ncs(fpga_ncs), .miso(miso), .miso_oe(miso_oe), .link(link.link_slave));

	robot_regs i_robot_regs (.sysclk(sysclk), .reset(reset), .link(link.link_regs),
		.fault(fault), .enc_count_1(enc_1), .enc_count_2(enc_2), .enc_count_3(enc_3),
		.enc_count_4(enc_4), .kick_status(kick_status), .speed_1(speed_1),
		.speed_2(speed_2), .speed_3(speed_3), .speed_4(speed_4), .speed_5(speed_5),
		.dir(dir), .charge_enable(charge_enable), .kick_request(kick_request),
		.kick_select(kick_select), .kick_strength(kick_strength));

	motor_array i_motor_array (.sysclk(sysclk), .reset(reset), .speed_1(speed_1),
		.speed_2(speed_2), .speed_3(speed_3), .speed_4(speed_4), .speed_5(speed_5),
		.dir(dir), .hall(hall), .bridge(bridge), .fault(fault));

	quad_encoder i_enc_1 (.sysclk(sysclk), .reset(reset), .enc_a(m1enc_a), .enc_b(m1enc_b),
		.count(enc_1));
	quad_encoder i_enc_2 (.sysclk(sysclk), .reset(reset), .enc_a(m2enc_a), .enc_b(m2enc_b),
		.count(enc_2));
	quad_encoder i_enc_3 (.sysclk(sysclk), .reset(reset), .enc_a(m3enc_a), .enc_b(m3enc_b),
		.count(enc_3));
	quad_encoder i_enc_4 (.sysclk(sysclk), .reset(reset), .enc_a(m4enc_a), .enc_b(m4enc_b),
		.count(enc_4));

	// Discharge button is active low
	kicker i_kicker (.sysclk(sysclk), .reset(reset), .kick_request(kick_request),
		.kick_select(kick_select), .kick_strength(kick_strength),
		.charge_enable(charge_enable), .discharge_n(discharge), .kdone(kdone),
		.kcharge(kcharge), .kkick(kkick), .kchip(kchip), .status(kick_status));

endmodule

`default_nettype wire

// File: tb_robot_fpga.sv
`timescale 1ns/1ps
`default_nettype none

module tb_robot_fpga;

	logic sysclk = 1'b0;
	logic reset;
	logic sck, mosi, fpga_ncs;
	wire miso, miso_oe;
	// Per motor {a,b,c}, motor 1 at index 0
	logic [4:0][2:0] hall;
	// Per motor {a_h, a_l, b_h, b_l, c_h, c_l}
	wire [4:0][5:0] br;
	logic [3:0] enc_a, enc_b;
	logic discharge, kdone;
	wire kcharge, kkick, kchip;

	integer seed = 48170;
	int errors = 0;
	int cycle = 0;

	// Reference model state
	logic [15:0] enc_model [4];
	int enc_pos [4];
	logic [8:0] m_speed [5];
	logic m_dir [5];
	logic m_charge, m_select, m_override;

	logic [7:0] tx_buf [16];
	logic [7:0] rx_buf [16];

	// Kicker pulse monitor
	int kick_high, chip_high, kick_rises, chip_rises;
	logic kkick_q = 1'b0;
	logic kchip_q = 1'b0;

	robot_fpga i_robot_fpga (.sysclk(sysclk), .reset(reset), .sck(sck), .mosi(mosi),
		.fpga_ncs(fpga_ncs), .miso(miso), .miso_oe(miso_oe),
		.m1hall_a(hall[0][2]), .m1hall_b(hall[0][1]), .m1hall_c(hall[0][0]),
		.m2hall_a(hall[1][2]), .m2hall_b(hall[1][1]), .m2hall_c(hall[1][0]),
		.m3hall_a(hall[2][2]), .m3hall_b(hall[2][1]), .m3hall_c(hall[2][0]),
		.m4hall_a(hall[3][2]), .m4hall_b(hall[3][1]), .m4hall_c(hall[3][0]),
		.m5hall_a(hall[4][2]), .m5hall_b(hall[4][1]), .m5hall_c(hall[4][0]),
		.m1a_h(br[0][5]), .m1a_l(br[0][4]), .m1b_h(br[0][3]), .m1b_l(br[0][2]),
		.m1c_h(br[0][1]), .m1c_l(br[0][0]),
		.m2a_h(br[1][5]), .m2a_l(br[1][4]), .m2b_h(br[1][3]), .m2b_l(br[1][2]),
		.m2c_h(br[1][1]), .m2c_l(br[1][0]),
		.m3a_h(br[2][5]), .m3a_l(br[2][4]), .m3b_h(br[2][3]), .m3b_l(br[2][2]),
		.m3c_h(br[2][1]), .m3c_l(br[2][0]),
		.m4a_h(br[3][5]), .m4a_l(br[3][4]), .m4b_h(br[3][3]), .m4b_l(br[3][2]),
		.m4c_h(br[3][1]), .m4c_l(br[3][0]),
		.m5a_h(br[4][5]), .m5a_l(br[4][4]), .m5b_h(br[4][3]), .m5b_l(br[4][2]),
		.m5c_h(br[4][1]), .m5c_l(br[4][0]),
		.m1enc_a(enc_a[0]), .m1enc_b(enc_b[0]), .m2enc_a(enc_a[1]), .m2enc_b(enc_b[1]),
		.m3enc_a(enc_a[2]), .m3enc_b(enc_b[2]), .m4enc_a(enc_a[3]), .m4enc_b(enc_b[3]),
		.discharge(discharge), .kdone(kdone), .kcharge(kcharge), .kkick(kkick),
		.kchip(kchip));

	always #50 sysclk = ~sysclk;

	// Cycle counter and pulse bookkeeping
	always @(posedge sysclk) begin
		cycle++;
		if (kkick) begin
			kick_high++;
		end
		if (kchip) begin
			chip_high++;
		end
		if (kkick && !kkick_q) begin
			kick_rises++;
		end
		if (kchip && !kchip_q) begin
			chip_rises++;
		end
		kkick_q = kkick;
		kchip_q = kchip;
	end

	task automatic fail_run(input string line);
		errors++;
		$display("%s", line);
		$display("Regression failed");
		$fatal(1, "stopped at the first error");
	endtask

	// Ends 10 ns after a rising edge, where inputs change
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sysclk);
		#10;
	endtask

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic random_bit();
		int r;
		r = $random(seed);
		return r[0];
	endfunction

	// Codes 1 to 6 are the legal hall states
	function automatic logic [2:0] legal_hall();
		int r;
		r = random_below(6) + 1;
		return r[2:0];
	endfunction

	// Quadrature sequence {a,b} with A leading
	function automatic logic [1:0] gray_ab(input int p);
		case (p)
			0: return 2'b00;
			1: return 2'b10;
			2: return 2'b11;
			default: return 2'b01;
		endcase
	endfunction

	// Six-step table, phase 0 is a; returns {a_h, a_l, b_h, b_l, c_h, c_l}
	function automatic logic [5:0] commutate(input logic [2:0] h, input logic d,
			input logic full);
		logic [3:0] pair;
		logic [1:0] hi, lo;
		logic [5:0] r;
		case (h)
			3'b100: pair = {2'd0, 2'd1};
			3'b110: pair = {2'd0, 2'd2};
			3'b010: pair = {2'd1, 2'd2};
			3'b011: pair = {2'd1, 2'd0};
			3'b001: pair = {2'd2, 2'd0};
			3'b101: pair = {2'd2, 2'd1};
			default: return 6'b000000;
		endcase
		// Reverse swaps the driving sides
		hi = d ? pair[1:0] : pair[3:2];
		lo = d ? pair[3:2] : pair[1:0];
		r = 6'b000000;
		r[5 - 2 * hi] = full;
		r[4 - 2 * lo] = 1'b1;
		return r;
	endfunction

	function automatic logic [7:0] status_model();
		return {2'b00, m_select, m_override, m_charge, m_charge & ~m_override, 1'b0, kdone};
	endfunction

	// Mode 0 master, SCK at sysclk/10, MISO sampled just before each rise
	task automatic spi_transfer(input int n);
		fpga_ncs = 1'b0;
		wait_cycles(5);
		for (int i = 0; i < n; i++) begin
			for (int b = 7; b >= 0; b--) begin
				mosi = tx_buf[i][b];
				wait_cycles(5);
				assert (miso_oe === 1'b1) else
					fail_run($sformatf("mismatch at %0t: MISO enable off in a transfer", $time));
				rx_buf[i][b] = miso;
				sck = 1'b1;
				wait_cycles(5);
				sck = 1'b0;
			end
		end
		wait_cycles(5);
		fpga_ncs = 1'b1;
		wait_cycles(8);
	endtask

	task automatic check_byte(input int i, input logic [7:0] want);
		assert (rx_buf[i] === want) else
			fail_run($sformatf("mismatch at %0t: MISO byte %0d is %h, expected %h",
				$time, i, rx_buf[i], want));
	endtask

	// Motor write built from the model command
	task automatic build_write(input logic [7:0] strength);
		tx_buf[0] = robocup_pkg::CMD_WRITE_MOTORS;
		for (int m = 0; m < 5; m++) begin
			tx_buf[2 * m + 1] = m_speed[m][7:0];
			tx_buf[2 * m + 2] = {6'b000000, m_dir[m], m_speed[m][8]};
		end
		// Byte 10 shares motor 5's high byte with charge and select
		tx_buf[10] = tx_buf[10] | {m_charge, m_select, 6'b000000};
		tx_buf[11] = strength;
	endtask

	task automatic check_read(input logic [4:0] fault_want);
		tx_buf[0] = robocup_pkg::CMD_READ_STATUS;
		for (int i = 1; i < 11; i++) begin
			tx_buf[i] = 8'h00;
		end
		spi_transfer(11);
		check_byte(0, robocup_pkg::LOGIC_VERSION);
		// Counts low byte first
		for (int e = 0; e < 4; e++) begin
			check_byte(2 * e + 1, enc_model[e][7:0]);
			check_byte(2 * e + 2, enc_model[e][15:8]);
		end
		check_byte(9, {3'b000, fault_want});
		check_byte(10, status_model());
	endtask

	task automatic check_unknown();
		int code;
		code = random_below(254) + 2;
		tx_buf[0] = code[7:0];
		for (int i = 1; i < 6; i++) begin
			code = $random(seed);
			tx_buf[i] = code[7:0];
		end
		spi_transfer(6);
		check_byte(0, robocup_pkg::LOGIC_VERSION);
		for (int i = 1; i < 6; i++) begin
			check_byte(i, robocup_pkg::INVALID_FILL);
		end
	endtask

	// Random walk, each encoder steps -1, 0 or +1
	task automatic encoder_walk(input int steps);
		int move;
		for (int s = 0; s < steps; s++) begin
			for (int e = 0; e < 4; e++) begin
				move = random_below(3);
				if (move == 1) begin
					enc_pos[e] = (enc_pos[e] + 1) % 4;
					enc_model[e] = enc_model[e] + 16'd1;
				end else if (move == 2) begin
					enc_pos[e] = (enc_pos[e] + 3) % 4;
					enc_model[e] = enc_model[e] - 16'd1;
				end
				{enc_a[e], enc_b[e]} = gray_ab(enc_pos[e]);
			end
			wait_cycles(4);
		end
	endtask

	task automatic check_bridges();
		logic [5:0] want [5];
		logic ok;
		int t;
		for (int m = 0; m < 5; m++) begin
			want[m] = commutate(hall[m], m_dir[m], m_speed[m] != 9'd0);
		end
		ok = 1'b0;
		t = 0;
		while (!ok && t < 10) begin
			ok = 1'b1;
			for (int m = 0; m < 5; m++) begin
				if (br[m] !== want[m]) begin
					ok = 1'b0;
				end
			end
			if (!ok) begin
				wait_cycles(1);
				t++;
			end
		end
		for (int m = 0; m < 5; m++) begin
			assert (br[m] === want[m]) else
				fail_run($sformatf("mismatch at %0t: motor %0d bridge %b, expected %b",
					$time, m + 1, br[m], want[m]));
		end
	endtask

	task automatic wait_kcharge(input logic level);
		int t;
		t = 0;
		while (kcharge !== level && t < 50) begin
			wait_cycles(1);
			t++;
		end
		assert (kcharge === level) else
			fail_run($sformatf("timeout at %0t: kcharge never went to %0b", $time, level));
	endtask

	initial begin
		int t;
		int strength;
		int fault_motor;
		int last_write;
		reset = 1'b1;
		sck = 1'b0;
		mosi = 1'b0;
		fpga_ncs = 1'b1;
		enc_a = 4'b0000;
		enc_b = 4'b0000;
		discharge = 1'b1;
		kdone = random_bit();
		for (int m = 0; m < 5; m++) begin
			hall[m] = legal_hall();
			m_speed[m] = 9'd0;
			m_dir[m] = 1'b0;
		end
		for (int e = 0; e < 4; e++) begin
			enc_model[e] = 16'd0;
			enc_pos[e] = 0;
		end
		m_charge = 1'b0;
		m_select = 1'b0;
		m_override = 1'b0;
		wait_cycles(5);
		reset = 1'b0;
		assert (br === '0 && !kcharge && !kkick && !kchip && miso_oe === 1'b0) else
			fail_run($sformatf("mismatch at %0t: outputs not idle after reset", $time));

		// Reads of random encoder walks, and unknown commands
		for (int r = 0; r < 4; r++) begin
			encoder_walk(30);
			wait_cycles(4);
			check_read(5'b00000);
			check_unknown();
		end

		// Commutation with random direction at zero or full speed
		for (int w = 0; w < 6; w++) begin
			for (int m = 0; m < 5; m++) begin
				m_dir[m] = random_bit();
				m_speed[m] = random_bit() ? 9'd511 : 9'd0;
			end
			m_charge = 1'b1;
			build_write(8'd0);
			spi_transfer(12);
			for (int h = 0; h < 8; h++) begin
				for (int m = 0; m < 5; m++) begin
					hall[m] = legal_hall();
				end
				check_bridges();
			end
		end
		// Short write with other speed and direction for motor 1
		build_write(8'd0);
		tx_buf[1] = ~tx_buf[1];
		tx_buf[2] = tx_buf[2] ^ 8'h03;
		spi_transfer(11);
		wait_cycles(10);
		check_bridges();

		// Hall fault on one motor
		fault_motor = random_below(5);
		hall[fault_motor] = random_bit() ? 3'b111 : 3'b000;
		check_bridges();
		check_read(5'b00001 << fault_motor);
		hall[fault_motor] = legal_hall();
		check_bridges();

		// Kick, then a second kick inside the lockout
		for (int m = 0; m < 5; m++) begin
			m_speed[m] = 9'd511;
			m_dir[m] = random_bit();
		end
		m_select = random_bit();
		strength = random_below(255) + 1;
		kick_high = 0;
		chip_high = 0;
		kick_rises = 0;
		chip_rises = 0;
		build_write(strength[7:0]);
		spi_transfer(12);
		t = 0;
		while (!(kick_rises + chip_rises >= 1 && !kkick && !kchip) && t < 6000) begin
			wait_cycles(1);
			t++;
		end
		assert (kick_rises + chip_rises >= 1 && !kkick && !kchip) else
			fail_run("timeout: kick pulse did not start or did not end");
		// Pulse just ended, a full write lands well inside the lockout
		build_write(8'(random_below(255) + 1));
		spi_transfer(12);
		last_write = cycle;
		wait_cycles(50);
		assert (kick_rises == (m_select ? 0 : 1) && chip_rises == (m_select ? 1 : 0)) else
			fail_run($sformatf("mismatch at %0t: %0d kick and %0d chip pulses, select %0b",
				$time, kick_rises, chip_rises, m_select));
		assert (kick_high + chip_high == strength * int'(robocup_pkg::KICK_SCALE)) else
			fail_run($sformatf("mismatch at %0t: pulse of %0d cycles for strength %0d",
				$time, kick_high + chip_high, strength));

		// Watchdog stops the high sides and the charger
		t = 0;
		while (((br & {5{6'b101010}}) != '0 || kcharge !== 1'b0) && t < 70000) begin
			wait_cycles(1);
			t++;
		end
		assert ((br & {5{6'b101010}}) == '0 && kcharge === 1'b0) else
			fail_run("timeout: watchdog never stopped the motors and the charger");
		assert (cycle - last_write > 65000) else
			fail_run($sformatf("mismatch at %0t: watchdog fired %0d cycles after a write",
				$time, cycle - last_write));
		for (int m = 0; m < 5; m++) begin
			m_speed[m] = 9'd0;
			m_dir[m] = 1'b0;
		end
		m_charge = 1'b0;
		check_bridges();

		// Discharge button overrides charging until reset
		m_charge = 1'b1;
		build_write(8'd0);
		spi_transfer(12);
		wait_kcharge(1'b1);
		discharge = 1'b0;
		wait_cycles(3);
		discharge = 1'b1;
		wait_kcharge(1'b0);
		m_override = 1'b1;
		build_write(8'd0);
		spi_transfer(12);
		wait_cycles(10);
		assert (kcharge === 1'b0) else
			fail_run($sformatf("mismatch at %0t: kcharge back on under override", $time));
		check_read(5'b00000);
		reset = 1'b1;
		wait_cycles(5);
		reset = 1'b0;
		m_override = 1'b0;
		m_select = 1'b0;
		for (int e = 0; e < 4; e++) begin
			enc_model[e] = 16'd0;
		end
		build_write(8'd0);
		spi_transfer(12);
		wait_kcharge(1'b1);
		check_read(5'b00000);

		if (errors == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "run ended with errors");
		end
	end

endmodule

`default_nettype wire

// File: verilog.f
robocup_pkg.sv
spi_link_if.sv
spi_slave.sv
robot_regs.sv
motor_driver.sv
motor_array.sv
quad_encoder.sv
kicker.sv
robot_fpga.sv
tb_robot_fpga.sv

// File: Bender.yml
package:
  name: robot_fpga

sources:
  - robocup_pkg.sv
  - spi_link_if.sv
  - spi_slave.sv
  - robot_regs.sv
  - motor_driver.sv
  - motor_array.sv
  - quad_encoder.sv
  - kicker.sv
  - robot_fpga.sv
  - target: simulation
    files:
      - tb_robot_fpga.sv
